/* hdl/rvv_macros.svh */
/* width macros for the vector decode packages and RTL
   RVV_FU_NUM must equal the number of fu_type_t members */
`ifndef RVV_MACROS_SVH
`define RVV_MACROS_SVH

// instruction and field widths
`define RVV_INSTR_W   32
`define RVV_REG_W     5
`define RVV_FUNCT6_W  6
`define RVV_FUNCT3_W  3

// mask logical op encoding
`define RVV_MASK_OP_W 2

// one enable bit per functional unit
`define RVV_FU_NUM    7

`endif

/* hdl/rvv_isa_pkg.sv */
/* RVV 1.0 encodings for the supported integer subset only
   funct3 codes for the FP categories are left out on purpose */
`include "rvv_macros.svh"

package rvv_isa_pkg;

  // major opcodes
  typedef enum logic [6:0] {
    LOAD_FP  = 7'b0000111,
    STORE_FP = 7'b0100111,
    VECTOR   = 7'b1010111
  } opcode_t;

  typedef enum logic [`RVV_FUNCT3_W-1:0] {
    OPIVV = 3'b000,
    OPMVV = 3'b010,
    OPIVI = 3'b011,
    OPIVX = 3'b100,
    OPMVX = 3'b110,
    OPCFG = 3'b111
  } vfunct3_t;

  // integer ops in the OPI space
  typedef enum logic [`RVV_FUNCT6_W-1:0] {
    VADD   = 6'b000000,
    VSUB   = 6'b000010,
    VRSUB  = 6'b000011,
    VMINU  = 6'b000100,
    VMIN   = 6'b000101,
    VMAXU  = 6'b000110,
    VMAX   = 6'b000111,
    VAND   = 6'b001001,
    VOR    = 6'b001010,
    VXOR   = 6'b001011,
    VMSEQ  = 6'b011000,
    VMSNE  = 6'b011001,
    VMSLTU = 6'b011010,
    VMSLT  = 6'b011011,
    VMSLEU = 6'b011100,
    VMSLE  = 6'b011101,
    VMSGTU = 6'b011110,
    VMSGT  = 6'b011111,
    VSLL   = 6'b100101,
    VSRL   = 6'b101000,
    VSRA   = 6'b101001
  } vopi_t;

  // reductions, mask logicals, multiply and divide in the OPM space
  typedef enum logic [`RVV_FUNCT6_W-1:0] {
    VREDSUM  = 6'b000000,
    VREDAND  = 6'b000001,
    VREDOR   = 6'b000010,
    VREDXOR  = 6'b000011,
    VREDMINU = 6'b000100,
    VREDMIN  = 6'b000101,
    VREDMAXU = 6'b000110,
    VREDMAX  = 6'b000111,
    VMANDN   = 6'b011000,
    VMAND    = 6'b011001,
    VMOR     = 6'b011010,
    VMXOR    = 6'b011011,
    VMORN    = 6'b011100,
    VMNAND   = 6'b011101,
    VMNOR    = 6'b011110,
    VMXNOR   = 6'b011111,
    VDIVU    = 6'b100000,
    VDIV     = 6'b100001,
    VREMU    = 6'b100010,
    VREM     = 6'b100011,
    VMULHU   = 6'b100100,
    VMUL     = 6'b100101,
    VMULHSU  = 6'b100110,
    VMULH    = 6'b100111
  } vopm_t;

  // memory element width, funct3 of a vector load or store
  typedef enum logic [2:0] {
    WIDTH8  = 3'b000,
    WIDTH16 = 3'b101,
    WIDTH32 = 3'b110
  } width_t;

  typedef enum logic [1:0] {
    MOP_UNIT    = 2'b00,
    MOP_STRIDED = 2'b10
  } mop_t;

  typedef enum logic [1:0] {
    NOT_CFG,
    VSETVLI,
    VSETIVLI,
    VSETVL
  } cfgsel_t;

endpackage

/* hdl/rvv_ctrl_pkg.sv */
/* decoded control types for the execution stage
   OP_BAD and ARITH must stay at encoding zero, the reset value of the control bundle */
`include "rvv_macros.svh"

package rvv_ctrl_pkg;

  typedef enum logic [5:0] {
    OP_BAD = 6'd0,
    OP_VADD, OP_VSUB, OP_VRSUB,
    OP_VMINU, OP_VMIN, OP_VMAXU, OP_VMAX,
    OP_VAND, OP_VOR, OP_VXOR,
    OP_VMSEQ, OP_VMSNE, OP_VMSLTU, OP_VMSLT,
    OP_VMSLEU, OP_VMSLE, OP_VMSGTU, OP_VMSGT,
    OP_VSLL, OP_VSRL, OP_VSRA,
    OP_VREDSUM, OP_VREDAND, OP_VREDOR, OP_VREDXOR,
    OP_VREDMINU, OP_VREDMIN, OP_VREDMAXU, OP_VREDMAX,
    OP_VMANDN, OP_VMAND, OP_VMOR, OP_VMXOR,
    OP_VMORN, OP_VMNAND, OP_VMNOR, OP_VMXNOR,
    OP_VMUL, OP_VMULH, OP_VMULHU, OP_VMULHSU,
    OP_VDIVU, OP_VDIV, OP_VREMU, OP_VREM
  } vop_t;

  // value doubles as the bit index into the unit enables
  typedef enum logic [2:0] {
    ARITH, RED, MUL, DIV, MASK, LOAD_UNIT, STORE_UNIT
  } fu_type_t;

  typedef enum logic [3:0] {
    VALU_SLL, VALU_SRL, VALU_SRA, VALU_ADD, VALU_SUB,
    VALU_AND, VALU_OR, VALU_XOR, VALU_COMP, VALU_MM
  } valu_op_t;

  typedef enum logic [2:0] {
    VSEQ, VSNE, VSLTU, VSLT, VSLEU, VSLE, VSGTU, VSGT
  } comp_t;

  typedef enum logic [1:0] {MIN, MINU, MAX, MAXU} minmax_t;

  typedef enum logic [1:0] {UNSIGNED, SIGNED, SIGNED_UNSIGNED} sign_t;

  typedef enum logic [`RVV_MASK_OP_W-1:0] {
    VMASK_NONE, VMASK_AND, VMASK_OR, VMASK_XOR
  } vmask_op_t;

  // vector register, scalar register or immediate
  typedef enum logic [1:0] {V, X, I} src_type_t;

  typedef struct packed {
    logic [`RVV_REG_W-1:0] vd;
    logic [`RVV_REG_W-1:0] vs1;
    logic [`RVV_REG_W-1:0] vs2;
    logic                  vm;
    logic [`RVV_REG_W-1:0] imm_5;
    logic [2:0]            nf;
    rvv_isa_pkg::mop_t     mop;
    rvv_isa_pkg::width_t   mem_width;
  } vinstr_fields_t;

  typedef struct packed {
    rvv_isa_pkg::opcode_t  opcode;
    rvv_isa_pkg::vfunct3_t vfunct3;
    logic                  is_vopi;
    logic                  is_vopm;
    logic                  is_load;
    logic                  is_store;
    rvv_isa_pkg::cfgsel_t  cfgsel;
  } vinstr_class_t;

  typedef struct packed {
    fu_type_t               fu_type;
    logic [`RVV_FU_NUM-1:0] fu_ena;
    valu_op_t               aluop;
    comp_t                  comp_type;
    minmax_t                minmax_type;
    sign_t                  is_signed;
    vmask_op_t              mask_type;
    logic                   out_inv;
    logic                   in_inv;
    logic                   single_bit_op;
    logic                   high_low;
    logic                   div_rem;
  } vexec_ctrl_t;

  typedef struct packed {
    logic       illegal_insn;
    logic       de_en;
    logic [1:0] wen;
    logic       dren;
    logic       dwen;
    src_type_t  rs1_type;
    src_type_t  rs2_type;
    logic       imm_op;
    logic       sign_extend;
    logic       stride;
  } vissue_ctrl_t;

  typedef struct packed {
    vinstr_fields_t fields;
    vop_t           vop;
    vexec_ctrl_t    exec;
    vissue_ctrl_t   issue;
  } vdecode_out_t;

endpackage

/* hdl/vinstr_classifier.sv */
/* field slicing and opcode classification, purely combinational
   loads and stores only count with an 8, 16 or 32 bit element width */
`timescale 1ns/1ps
`include "rvv_macros.svh"

module vinstr_classifier (
  input  logic [`RVV_INSTR_W-1:0]  instr,
  output rvv_ctrl_pkg::vinstr_fields_t fields,
  output rvv_ctrl_pkg::vinstr_class_t  cls
);
  import rvv_isa_pkg::*;

  logic width_ok;

  always_comb begin
    fields.vd        = instr[11:7];
    fields.vs1       = instr[19:15];
    fields.vs2       = instr[24:20];
    fields.vm        = instr[25];
    fields.imm_5     = instr[19:15];
    fields.nf        = instr[31:29];
    fields.mop       = mop_t'(instr[27:26]);
    fields.mem_width = width_t'(instr[14:12]);

    cls.opcode  = opcode_t'(instr[6:0]);
    cls.vfunct3 = vfunct3_t'(instr[14:12]);

    width_ok     = fields.mem_width inside {WIDTH8, WIDTH16, WIDTH32};
    cls.is_load  = (cls.opcode == LOAD_FP) && width_ok;
    cls.is_store = (cls.opcode == STORE_FP) && width_ok;
    cls.is_vopi  = (cls.opcode == VECTOR) &&
                   (cls.vfunct3 inside {OPIVV, OPIVX, OPIVI});
    cls.is_vopm  = (cls.opcode == VECTOR) && (cls.vfunct3 inside {OPMVV, OPMVX});

    // vsetvli has bit 31 clear, the other two are told apart by bit 30
    cls.cfgsel = NOT_CFG;
    if ((cls.opcode == VECTOR) && (cls.vfunct3 == OPCFG)) begin
      if (!instr[31]) begin
        cls.cfgsel = VSETVLI;
      end else if (instr[30]) begin
        cls.cfgsel = VSETIVLI;
      end else begin
        cls.cfgsel = VSETVL;
      end
    end

    if (!$isunknown(instr)) begin
      assert ($onehot0({cls.is_vopi, cls.is_vopm, cls.is_load, cls.is_store}))
        else $error("instruction falls in more than one class");
    end
  end

endmodule

/* hdl/vop_decoder.sv */
/* funct6 decode for the kept OPI and OPM integer ops
   forms that RVV 1.0 does not define for an op decode to OP_BAD */
`timescale 1ns/1ps
`include "rvv_macros.svh"

module vop_decoder (
  input  rvv_ctrl_pkg::vinstr_class_t cls,
  input  logic [`RVV_FUNCT6_W-1:0]    funct6,
  output rvv_ctrl_pkg::vop_t          vop
);
  import rvv_isa_pkg::*;
  import rvv_ctrl_pkg::*;

  vopi_t f6_opi;
  vopm_t f6_opm;
  logic  form_vvx;
  logic  form_vxi;
  logic  form_mvv;

  assign f6_opi = vopi_t'(funct6);
  assign f6_opm = vopm_t'(funct6);

  // permitted operand forms, only meaningful inside the matching space
  assign form_vvx = (cls.vfunct3 == OPIVV) || (cls.vfunct3 == OPIVX);
  assign form_vxi = (cls.vfunct3 == OPIVX) || (cls.vfunct3 == OPIVI);
  assign form_mvv = (cls.vfunct3 == OPMVV);

  always_comb begin
    vop = OP_BAD;
    if (cls.is_vopi) begin
      // is_vopi already limits funct3 to vv, vx and vi
      case (f6_opi)
        VADD:    vop = OP_VADD;
        VSUB:    vop = form_vvx ? OP_VSUB : OP_BAD;
        VRSUB:   vop = form_vxi ? OP_VRSUB : OP_BAD;
        VMINU:   vop = form_vvx ? OP_VMINU : OP_BAD;
        VMIN:    vop = form_vvx ? OP_VMIN : OP_BAD;
        VMAXU:   vop = form_vvx ? OP_VMAXU : OP_BAD;
        VMAX:    vop = form_vvx ? OP_VMAX : OP_BAD;
        VAND:    vop = OP_VAND;
        VOR:     vop = OP_VOR;
        VXOR:    vop = OP_VXOR;
        VMSEQ:   vop = OP_VMSEQ;
        VMSNE:   vop = OP_VMSNE;
        VMSLTU:  vop = form_vvx ? OP_VMSLTU : OP_BAD;
        VMSLT:   vop = form_vvx ? OP_VMSLT : OP_BAD;
        VMSLEU:  vop = OP_VMSLEU;
        VMSLE:   vop = OP_VMSLE;
        VMSGTU:  vop = form_vxi ? OP_VMSGTU : OP_BAD;
        VMSGT:   vop = form_vxi ? OP_VMSGT : OP_BAD;
        VSLL:    vop = OP_VSLL;
        VSRL:    vop = OP_VSRL;
        VSRA:    vop = OP_VSRA;
        default: vop = OP_BAD;
      endcase
    end else if (cls.is_vopm) begin
      // is_vopm leaves only mvv and mvx, so mul and div need no form check
      case (f6_opm)
        VREDSUM:  vop = form_mvv ? OP_VREDSUM : OP_BAD;
        VREDAND:  vop = form_mvv ? OP_VREDAND : OP_BAD;
        VREDOR:   vop = form_mvv ? OP_VREDOR : OP_BAD;
        VREDXOR:  vop = form_mvv ? OP_VREDXOR : OP_BAD;
        VREDMINU: vop = form_mvv ? OP_VREDMINU : OP_BAD;
        VREDMIN:  vop = form_mvv ? OP_VREDMIN : OP_BAD;
        VREDMAXU: vop = form_mvv ? OP_VREDMAXU : OP_BAD;
        VREDMAX:  vop = form_mvv ? OP_VREDMAX : OP_BAD;
        VMANDN:   vop = form_mvv ? OP_VMANDN : OP_BAD;
        VMAND:    vop = form_mvv ? OP_VMAND : OP_BAD;
        VMOR:     vop = form_mvv ? OP_VMOR : OP_BAD;
        VMXOR:    vop = form_mvv ? OP_VMXOR : OP_BAD;
        VMORN:    vop = form_mvv ? OP_VMORN : OP_BAD;
        VMNAND:   vop = form_mvv ? OP_VMNAND : OP_BAD;
        VMNOR:    vop = form_mvv ? OP_VMNOR : OP_BAD;
        VMXNOR:   vop = form_mvv ? OP_VMXNOR : OP_BAD;
        VDIVU:    vop = OP_VDIVU;
        VDIV:     vop = OP_VDIV;
        VREMU:    vop = OP_VREMU;
        VREM:     vop = OP_VREM;
        VMULHU:   vop = OP_VMULHU;
        VMUL:     vop = OP_VMUL;
        VMULHSU:  vop = OP_VMULHSU;
        VMULH:    vop = OP_VMULH;
        default:  vop = OP_BAD;
      endcase
    end
  end

endmodule

/* hdl/vexec_ctrl_gen.sv */
/* execution unit and ALU control from the decoded op
   loads and stores enable their own unit, OP_BAD enables none */
`timescale 1ns/1ps
`include "rvv_macros.svh"

module vexec_ctrl_gen (
  input  rvv_ctrl_pkg::vop_t        vop,
  input  logic                      is_load,
  input  logic                      is_store,
  output rvv_ctrl_pkg::vexec_ctrl_t exec
);
  import rvv_ctrl_pkg::*;

  fu_type_t fu;
  logic     unit_ok;

  always_comb begin
    exec    = '0;
    fu      = ARITH;
    unit_ok = 1'b1;
    if (is_load) begin
      fu = LOAD_UNIT;
    end else if (is_store) begin
      fu = STORE_UNIT;
    end else begin
      case (vop)
        OP_VREDSUM, OP_VREDAND, OP_VREDOR, OP_VREDXOR,
        OP_VREDMINU, OP_VREDMIN, OP_VREDMAXU, OP_VREDMAX: fu = RED;
        OP_VMANDN, OP_VMAND, OP_VMOR, OP_VMXOR,
        OP_VMORN, OP_VMNAND, OP_VMNOR, OP_VMXNOR:         fu = MASK;
        OP_VMUL, OP_VMULH, OP_VMULHU, OP_VMULHSU:         fu = MUL;
        OP_VDIVU, OP_VDIV, OP_VREMU, OP_VREM:             fu = DIV;
        OP_BAD:                                           unit_ok = 1'b0;
        default:                                          fu = ARITH;
      endcase
    end
    exec.fu_type = fu;
    exec.fu_ena  = unit_ok ? (`RVV_FU_NUM'(1) << fu) : '0;

    case (vop)
      OP_VSLL: exec.aluop = VALU_SLL;
      OP_VSRL: exec.aluop = VALU_SRL;
      OP_VSRA: exec.aluop = VALU_SRA;
      OP_VADD, OP_VREDSUM: exec.aluop = VALU_ADD;
      OP_VSUB, OP_VRSUB: exec.aluop = VALU_SUB;
      OP_VAND, OP_VREDAND, OP_VMANDN, OP_VMAND, OP_VMNAND: exec.aluop = VALU_AND;
      OP_VOR, OP_VREDOR, OP_VMOR, OP_VMORN, OP_VMNOR: exec.aluop = VALU_OR;
      OP_VXOR, OP_VREDXOR, OP_VMXOR, OP_VMXNOR: exec.aluop = VALU_XOR;
      OP_VMSEQ, OP_VMSNE, OP_VMSLTU, OP_VMSLT,
      OP_VMSLEU, OP_VMSLE, OP_VMSGTU, OP_VMSGT: exec.aluop = VALU_COMP;
      OP_VMINU, OP_VMIN, OP_VMAXU, OP_VMAX,
      OP_VREDMINU, OP_VREDMIN, OP_VREDMAXU, OP_VREDMAX: exec.aluop = VALU_MM;
      default: exec.aluop = VALU_SLL;
    endcase

    case (vop)
      OP_VMSNE:  exec.comp_type = VSNE;
      OP_VMSLTU: exec.comp_type = VSLTU;
      OP_VMSLT:  exec.comp_type = VSLT;
      OP_VMSLEU: exec.comp_type = VSLEU;
      OP_VMSLE:  exec.comp_type = VSLE;
      OP_VMSGTU: exec.comp_type = VSGTU;
      OP_VMSGT:  exec.comp_type = VSGT;
      default:   exec.comp_type = VSEQ;
    endcase

    case (vop)
      OP_VMINU, OP_VREDMINU: exec.minmax_type = MINU;
      OP_VMAX, OP_VREDMAX:   exec.minmax_type = MAX;
      OP_VMAXU, OP_VREDMAXU: exec.minmax_type = MAXU;
      default:               exec.minmax_type = MIN;
    endcase

    case (vop)
      OP_VADD, OP_VSUB, OP_VRSUB, OP_VMIN, OP_VMAX, OP_VMSEQ, OP_VMSNE,
      OP_VMSLT, OP_VMSLE, OP_VMSGT, OP_VREDSUM, OP_VREDMIN, OP_VREDMAX,
      OP_VMUL, OP_VMULH, OP_VDIV, OP_VREM: exec.is_signed = SIGNED;
      // vs2 signed, vs1 unsigned
      OP_VMULHSU: exec.is_signed = SIGNED_UNSIGNED;
      default:    exec.is_signed = UNSIGNED;
    endcase

    case (vop)
      OP_VMANDN, OP_VMAND, OP_VMNAND: exec.mask_type = VMASK_AND;
      OP_VMOR, OP_VMORN, OP_VMNOR:    exec.mask_type = VMASK_OR;
      OP_VMXOR, OP_VMXNOR:            exec.mask_type = VMASK_XOR;
      default:                        exec.mask_type = VMASK_NONE;
    endcase

    exec.out_inv       = vop inside {OP_VMNAND, OP_VMNOR, OP_VMXNOR};
    exec.in_inv        = vop inside {OP_VMANDN, OP_VMORN};
    exec.single_bit_op = (exec.aluop == VALU_COMP);
    exec.high_low      = vop inside {OP_VMULH, OP_VMULHU, OP_VMULHSU};
    // set selects the quotient, clear the remainder
    exec.div_rem       = vop inside {OP_VDIV, OP_VDIVU};

    if (!$isunknown({vop, is_load, is_store})) begin
      assert ($onehot0(exec.fu_ena))
        else $error("more than one functional unit enabled");
    end
  end

endmodule

/* hdl/vissue_ctrl_gen.sv */
/* issue-side controls: legality, enables and operand sources
   any opcode other than VECTOR, loads and stores included, raises illegal_insn */
`timescale 1ns/1ps

module vissue_ctrl_gen (
  input  rvv_ctrl_pkg::vinstr_class_t cls,
  input  rvv_isa_pkg::mop_t           mop,
  input  rvv_ctrl_pkg::vop_t          vop,
  output rvv_ctrl_pkg::vissue_ctrl_t  issue
);
  import rvv_isa_pkg::*;
  import rvv_ctrl_pkg::*;

  logic is_vec;
  logic is_cfg;
  logic is_arith;
  logic is_mem;
  logic scalar_rs1;

  assign is_vec   = (cls.opcode == VECTOR);
  assign is_cfg   = (cls.cfgsel != NOT_CFG);
  assign is_arith = cls.is_vopi || cls.is_vopm;
  assign is_mem   = cls.is_load || cls.is_store;

  // vsetivli takes its avl from the immediate, so it stays out of this list
  assign scalar_rs1 = is_mem || (is_vec && (cls.vfunct3 inside {OPIVX, OPMVX})) ||
                      (cls.cfgsel == VSETVLI) || (cls.cfgsel == VSETVL);

  always_comb begin
    issue.illegal_insn = !is_vec || !(is_arith || is_cfg) || (is_arith && (vop == OP_BAD));
    issue.de_en        = is_vec && !issue.illegal_insn && !is_cfg;
    issue.wen          = (cls.is_load || is_arith) ? 2'b11 : 2'b00;
    issue.dren         = cls.is_load;
    issue.dwen         = cls.is_store;
    issue.imm_op       = is_vec && (cls.vfunct3 inside {OPIVI, OPCFG});
    issue.rs1_type     = scalar_rs1 ? X : (issue.imm_op ? I : V);
    issue.stride       = is_mem && (mop == MOP_STRIDED);
    issue.rs2_type     = issue.stride ? X : V;
    // shift amounts and the vsetivli avl are unsigned immediates
    issue.sign_extend  = !((vop inside {OP_VSLL, OP_VSRL, OP_VSRA}) ||
                           (cls.cfgsel == VSETIVLI));
  end

endmodule

/* hdl/vector_control_unit.sv */
/* one-stage vector decode, result registered on each instr_valid strobe
   no back-pressure, ctrl holds its value while instr_valid is low */
`timescale 1ns/1ps
`include "rvv_macros.svh"

module vector_control_unit (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       instr_valid,
  input  logic [`RVV_INSTR_W-1:0]    instr,
  output logic                       ctrl_valid,
  output rvv_ctrl_pkg::vdecode_out_t ctrl
);
  import rvv_ctrl_pkg::*;

  vinstr_fields_t fields;
  vinstr_class_t  cls;
  vop_t           vop;
  vexec_ctrl_t    exec;
  vissue_ctrl_t   issue;
  vdecode_out_t   dec;

  vinstr_classifier vinstr_classifier_i (
    .instr  (instr),
    .fields (fields),
    .cls    (cls)
  );

  // funct6 sits in the top six bits of every arithmetic encoding
  vop_decoder vop_decoder_i (
    .cls    (cls),
    .funct6 (instr[`RVV_INSTR_W-1 -: `RVV_FUNCT6_W]),
    .vop    (vop)
  );

  vexec_ctrl_gen vexec_ctrl_gen_i (
    .vop      (vop),
    .is_load  (cls.is_load),
    .is_store (cls.is_store),
    .exec     (exec)
  );

  vissue_ctrl_gen vissue_ctrl_gen_i (
    .cls   (cls),
    .mop   (fields.mop),
    .vop   (vop),
    .issue (issue)
  );

  assign dec = '{fields: fields, vop: vop, exec: exec, issue: issue};

  always_ff @(posedge clk) begin
    if (rst) begin
      ctrl_valid <= 1'b0;
      ctrl       <= '0;
    end else begin
      ctrl_valid <= instr_valid;
      if (instr_valid) begin
        ctrl <= dec;
      end
    end
  end

  // one cycle from strobe to valid, never more and never dropped
  valid_latency_a: assert property (
    @(posedge clk) disable iff (rst)
    !$past(rst) |-> (ctrl_valid == $past(instr_valid))
  ) else $error("ctrl_valid does not follow instr_valid by one cycle");

endmodule

/* sim/vcu_ref_model.svh */
/* reference decode for the testbench scoreboard
   include inside a module that imports rvv_isa_pkg and rvv_ctrl_pkg */
`ifndef VCU_REF_MODEL_SVH
`define VCU_REF_MODEL_SVH

`include "rvv_macros.svh"

// op named by funct6 alone, the operand form is checked later
function automatic vop_t ref_raw_op(logic opi, logic [5:0] f6);
  vop_t op;
  op = OP_BAD;
  if (opi) begin
    case (vopi_t'(f6))
      VADD:    op = OP_VADD;
      VSUB:    op = OP_VSUB;
      VRSUB:   op = OP_VRSUB;
      VMINU:   op = OP_VMINU;
      VMIN:    op = OP_VMIN;
      VMAXU:   op = OP_VMAXU;
      VMAX:    op = OP_VMAX;
      VAND:    op = OP_VAND;
      VOR:     op = OP_VOR;
      VXOR:    op = OP_VXOR;
      VMSEQ:   op = OP_VMSEQ;
      VMSNE:   op = OP_VMSNE;
      VMSLTU:  op = OP_VMSLTU;
      VMSLT:   op = OP_VMSLT;
      VMSLEU:  op = OP_VMSLEU;
      VMSLE:   op = OP_VMSLE;
      VMSGTU:  op = OP_VMSGTU;
      VMSGT:   op = OP_VMSGT;
      VSLL:    op = OP_VSLL;
      VSRL:    op = OP_VSRL;
      VSRA:    op = OP_VSRA;
      default: op = OP_BAD;
    endcase
  end else begin
    case (vopm_t'(f6))
      VREDSUM:  op = OP_VREDSUM;
      VREDAND:  op = OP_VREDAND;
      VREDOR:   op = OP_VREDOR;
      VREDXOR:  op = OP_VREDXOR;
      VREDMINU: op = OP_VREDMINU;
      VREDMIN:  op = OP_VREDMIN;
      VREDMAXU: op = OP_VREDMAXU;
      VREDMAX:  op = OP_VREDMAX;
      VMANDN:   op = OP_VMANDN;
      VMAND:    op = OP_VMAND;
      VMOR:     op = OP_VMOR;
      VMXOR:    op = OP_VMXOR;
      VMORN:    op = OP_VMORN;
      VMNAND:   op = OP_VMNAND;
      VMNOR:    op = OP_VMNOR;
      VMXNOR:   op = OP_VMXNOR;
      VMUL:     op = OP_VMUL;
      VMULH:    op = OP_VMULH;
      VMULHU:   op = OP_VMULHU;
      VMULHSU:  op = OP_VMULHSU;
      VDIVU:    op = OP_VDIVU;
      VDIV:     op = OP_VDIV;
      VREMU:    op = OP_VREMU;
      VREM:     op = OP_VREM;
      default:  op = OP_BAD;
    endcase
  end
  return op;
endfunction

// permitted forms as bits, 0 for vv, 1 for vx, 2 for vi
function automatic logic form_allowed(vop_t op, logic [2:0] f3);
  logic [2:0] forms;
  int slot;
  if (op inside {OP_VSUB, OP_VMINU, OP_VMIN, OP_VMAXU, OP_VMAX, OP_VMSLTU, OP_VMSLT}) begin
    forms = 3'b011;
  end else if (op inside {OP_VRSUB, OP_VMSGTU, OP_VMSGT}) begin
    forms = 3'b110;
  end else if (op inside {[OP_VREDSUM:OP_VMXNOR]}) begin
    forms = 3'b001;
  end else begin
    forms = 3'b111;
  end
  case (f3)
    OPIVV, OPMVV: slot = 0;
    OPIVX, OPMVX: slot = 1;
    default:      slot = 2;
  endcase
  return forms[slot];
endfunction

function automatic vexec_ctrl_t ref_exec(vop_t op, logic ld, logic st);
  vexec_ctrl_t e;
  e = '0;
  if (ld) begin
    e.fu_type = LOAD_UNIT;
  end else if (st) begin
    e.fu_type = STORE_UNIT;
  end else if (op inside {[OP_VREDSUM:OP_VREDMAX]}) begin
    e.fu_type = RED;
  end else if (op inside {[OP_VMANDN:OP_VMXNOR]}) begin
    e.fu_type = MASK;
  end else if (op inside {OP_VMUL, OP_VMULH, OP_VMULHU, OP_VMULHSU}) begin
    e.fu_type = MUL;
  end else if (op inside {OP_VDIVU, OP_VDIV, OP_VREMU, OP_VREM}) begin
    e.fu_type = DIV;
  end else begin
    e.fu_type = ARITH;
  end
  if (ld || st || (op != OP_BAD)) begin
    e.fu_ena = `RVV_FU_NUM'(1) << e.fu_type;
  end

  case (op)
    OP_VSRL: e.aluop = VALU_SRL;
    OP_VSRA: e.aluop = VALU_SRA;
    OP_VADD, OP_VREDSUM: e.aluop = VALU_ADD;
    OP_VSUB, OP_VRSUB: e.aluop = VALU_SUB;
    OP_VAND, OP_VREDAND, OP_VMAND, OP_VMANDN, OP_VMNAND: e.aluop = VALU_AND;
    OP_VOR, OP_VREDOR, OP_VMOR, OP_VMORN, OP_VMNOR: e.aluop = VALU_OR;
    OP_VXOR, OP_VREDXOR, OP_VMXOR, OP_VMXNOR: e.aluop = VALU_XOR;
    OP_VMSEQ, OP_VMSNE, OP_VMSLTU, OP_VMSLT,
    OP_VMSLEU, OP_VMSLE, OP_VMSGTU, OP_VMSGT: e.aluop = VALU_COMP;
    OP_VMINU, OP_VMIN, OP_VMAXU, OP_VMAX,
    OP_VREDMINU, OP_VREDMIN, OP_VREDMAXU, OP_VREDMAX: e.aluop = VALU_MM;
    default: e.aluop = VALU_SLL;
  endcase

  case (op)
    OP_VMSNE:  e.comp_type = VSNE;
    OP_VMSLTU: e.comp_type = VSLTU;
    OP_VMSLT:  e.comp_type = VSLT;
    OP_VMSLEU: e.comp_type = VSLEU;
    OP_VMSLE:  e.comp_type = VSLE;
    OP_VMSGTU: e.comp_type = VSGTU;
    OP_VMSGT:  e.comp_type = VSGT;
    default:   e.comp_type = VSEQ;
  endcase

  if (op inside {OP_VMINU, OP_VREDMINU}) begin
    e.minmax_type = MINU;
  end else if (op inside {OP_VMAX, OP_VREDMAX}) begin
    e.minmax_type = MAX;
  end else if (op inside {OP_VMAXU, OP_VREDMAXU}) begin
    e.minmax_type = MAXU;
  end

  // signed flavours of each kept op
  if (op == OP_VMULHSU) begin
    e.is_signed = SIGNED_UNSIGNED;
  end else if (op inside {OP_VADD, OP_VSUB, OP_VRSUB, OP_VMIN, OP_VMAX, OP_VMSEQ,
                          OP_VMSNE, OP_VMSLT, OP_VMSLE, OP_VMSGT, OP_VREDSUM,
                          OP_VREDMIN, OP_VREDMAX, OP_VMUL, OP_VMULH, OP_VDIV,
                          OP_VREM}) begin
    e.is_signed = SIGNED;
  end

  if (op inside {OP_VMAND, OP_VMANDN, OP_VMNAND}) begin
    e.mask_type = VMASK_AND;
  end else if (op inside {OP_VMOR, OP_VMORN, OP_VMNOR}) begin
    e.mask_type = VMASK_OR;
  end else if (op inside {OP_VMXOR, OP_VMXNOR}) begin
    e.mask_type = VMASK_XOR;
  end

  e.out_inv       = op inside {OP_VMNAND, OP_VMNOR, OP_VMXNOR};
  e.in_inv        = op inside {OP_VMANDN, OP_VMORN};
  e.single_bit_op = op inside {[OP_VMSEQ:OP_VMSGT]};
  e.high_low      = op inside {OP_VMULH, OP_VMULHU, OP_VMULHSU};
  e.div_rem       = op inside {OP_VDIV, OP_VDIVU};
  return e;
endfunction

function automatic vdecode_out_t ref_decode(logic [`RVV_INSTR_W-1:0] w);
  vdecode_out_t d;
  logic [2:0] f3;
  logic vec;
  logic ld;
  logic st;
  logic opi;
  logic opm;
  logic cfg;
  logic scalar;
  d  = '0;
  f3 = w[14:12];

  d.fields.vd        = w[11:7];
  d.fields.vs1       = w[19:15];
  d.fields.vs2       = w[24:20];
  d.fields.vm        = w[25];
  d.fields.imm_5     = w[19:15];
  d.fields.nf        = w[31:29];
  d.fields.mop       = mop_t'(w[27:26]);
  d.fields.mem_width = width_t'(w[14:12]);

  vec = (w[6:0] == VECTOR);
  ld  = (w[6:0] == LOAD_FP) && (f3 inside {WIDTH8, WIDTH16, WIDTH32});
  st  = (w[6:0] == STORE_FP) && (f3 inside {WIDTH8, WIDTH16, WIDTH32});
  opi = vec && (f3 inside {OPIVV, OPIVX, OPIVI});
  opm = vec && (f3 inside {OPMVV, OPMVX});
  cfg = vec && (f3 == OPCFG);

  d.vop = OP_BAD;
  if (opi || opm) begin
    d.vop = ref_raw_op(opi, w[31:26]);
    if (!form_allowed(d.vop, f3)) begin
      d.vop = OP_BAD;
    end
  end
  d.exec = ref_exec(d.vop, ld, st);

  // only a known OPI or OPM op reaches the decode counter
  d.issue.illegal_insn = !(opi || opm || cfg) || (d.vop == OP_BAD && !cfg);
  d.issue.de_en        = (opi || opm) && (d.vop != OP_BAD);
  d.issue.wen          = (ld || opi || opm) ? 2'b11 : 2'b00;
  d.issue.dren         = ld;
  d.issue.dwen         = st;
  d.issue.imm_op       = vec && (f3 inside {OPIVI, OPCFG});
  // vsetvli and vsetvl read rs1, vsetivli has bits 31:30 at 11
  scalar = ld || st || (vec && (f3 inside {OPIVX, OPMVX})) || (cfg && w[31:30] != 2'b11);
  if (scalar) begin
    d.issue.rs1_type = X;
  end else if (d.issue.imm_op) begin
    d.issue.rs1_type = I;
  end else begin
    d.issue.rs1_type = V;
  end
  d.issue.stride      = (ld || st) && (w[27:26] == 2'b10);
  d.issue.rs2_type    = d.issue.stride ? X : V;
  d.issue.sign_extend = !((d.vop inside {OP_VSLL, OP_VSRL, OP_VSRA}) ||
                          (cfg && w[31:30] == 2'b11));
  return d;
endfunction

`endif

/* sim/tb_vector_control_unit.sv */
/* random decode test against the reference model, 2000 instructions
   stops at the first mismatch */
`timescale 1ns/1ps
`include "rvv_macros.svh"

module tb_vector_control_unit;
  import rvv_isa_pkg::*;
  import rvv_ctrl_pkg::*;

  `include "vcu_ref_model.svh"

  localparam int NUM_TESTS  = 2000;
  localparam int CLK_PERIOD = 40;
  // idle cycles average a third of the valid ones, so twice the count is ample
  localparam int MAX_CYCLES = 2 * NUM_TESTS + 20;

  logic                    clk;
  logic                    rst;
  logic                    instr_valid;
  logic [`RVV_INSTR_W-1:0] instr;
  logic                    ctrl_valid;
  vdecode_out_t            ctrl;

  integer       seed = 19096;
  int           sent;
  int           checked;
  vdecode_out_t exp_q[$];
  vdecode_out_t last_exp;

  vector_control_unit vector_control_unit_i (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .instr       (instr),
    .ctrl_valid  (ctrl_valid),
    .ctrl        (ctrl)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic end_with_failure();
    $display("Verification failed");
    $fatal(1, "run stopped after a failure");
  endtask

  task automatic check_fields(string name, vinstr_fields_t exp, vinstr_fields_t act);
    if (act !== exp) begin
      $display("ERROR %s: expected %p, actual %p", name, exp, act);
      end_with_failure();
    end
  endtask

  task automatic check_vop(string name, vop_t exp, vop_t act);
    if (act !== exp) begin
      $display("ERROR %s: expected %s, actual %s (%0d)", name, exp.name(), act.name(), act);
      end_with_failure();
    end
  endtask

  task automatic check_exec(string name, vexec_ctrl_t exp, vexec_ctrl_t act);
    if (act !== exp) begin
      $display("ERROR %s: expected %p, actual %p", name, exp, act);
      end_with_failure();
    end
  endtask

  task automatic check_issue(string name, vissue_ctrl_t exp, vissue_ctrl_t act);
    if (act !== exp) begin
      $display("ERROR %s: expected %p, actual %p", name, exp, act);
      end_with_failure();
    end
  endtask

  task automatic compare_ctrl(string name, vdecode_out_t exp);
    check_fields({name, " fields"}, exp.fields, ctrl.fields);
    check_vop({name, " vop"}, exp.vop, ctrl.vop);
    check_exec({name, " exec"}, exp.exec, ctrl.exec);
    check_issue({name, " issue"}, exp.issue, ctrl.issue);
  endtask

  // mostly kept OPI and OPM ops with any funct3, then memory, config and raw words
  function automatic logic [`RVV_INSTR_W-1:0] make_instr();
    logic [`RVV_INSTR_W-1:0] w;
    vopi_t f6_i;
    vopm_t f6_m;
    int    kind;
    int    steps;
    w    = $random(seed);
    kind = $unsigned($random(seed)) % 16;
    if (kind < 6) begin
      f6_i  = f6_i.first();
      steps = $unsigned($random(seed)) % f6_i.num();
      repeat (steps) f6_i = f6_i.next();
      w[31:26] = f6_i;
      w[6:0]   = VECTOR;
    end else if (kind < 10) begin
      f6_m  = f6_m.first();
      steps = $unsigned($random(seed)) % f6_m.num();
      repeat (steps) f6_m = f6_m.next();
      w[31:26] = f6_m;
      w[6:0]   = VECTOR;
    end else if (kind < 13) begin
      w[6:0] = w[31] ? LOAD_FP : STORE_FP;
      // a quarter keep a random, mostly unsupported width
      case ($unsigned($random(seed)) % 4)
        0:       w[14:12] = WIDTH8;
        1:       w[14:12] = WIDTH16;
        2:       w[14:12] = WIDTH32;
        default: w[14:12] = w[14:12];
      endcase
    end else if (kind < 15) begin
      w[6:0]   = VECTOR;
      w[14:12] = OPCFG;
    end
    return w;
  endfunction

  // stimulus, valid low about a quarter of the cycles
  initial begin
    rst         = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    sent        = 0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    while (sent < NUM_TESTS) begin
      @(posedge clk);
      if ($unsigned($random(seed)) % 4 == 0) begin
        instr_valid <= 1'b0;
        instr       <= $random(seed);
      end else begin
        instr_valid <= 1'b1;
        instr       <= make_instr();
        sent++;
      end
    end
    @(posedge clk);
    instr_valid <= 1'b0;
    repeat (3) @(posedge clk);
    if (exp_q.size() != 0 || checked != NUM_TESTS) begin
      $display("%0d of %0d instructions never came out of the DUT",
               NUM_TESTS - checked, NUM_TESTS);
      end_with_failure();
    end else begin
      $display("Verification passed");
      $finish;
    end
  end

  // scoreboard, samples pre-edge values at each rising edge
  initial begin
    checked  = 0;
    last_exp = '0;
    forever begin
      @(posedge clk);
      if (rst === 1'b0) begin
        if (ctrl_valid === 1'b1) begin
          if (exp_q.size() == 0) begin
            $display("ctrl_valid went high with no instruction sampled the cycle before");
            end_with_failure();
          end else begin
            last_exp = exp_q.pop_front();
            compare_ctrl($sformatf("instr %0d", checked), last_exp);
            checked++;
          end
        end else if (ctrl_valid === 1'b0) begin
          if (exp_q.size() != 0) begin
            $display("ctrl_valid stayed low one cycle after an instruction was sampled");
            end_with_failure();
          end else begin
            // ctrl keeps the last decode, or zero after reset
            compare_ctrl("hold", last_exp);
          end
        end else begin
          $display("ctrl_valid is unknown after reset");
          end_with_failure();
        end
        if (instr_valid) begin
          exp_q.push_back(ref_decode(instr));
        end
      end
    end
  end

  initial begin
    #(MAX_CYCLES * CLK_PERIOD);
    $display("watchdog expired before all instructions were checked");
    end_with_failure();
  end

endmodule

/* files.f */
+incdir+hdl
+incdir+sim
hdl/rvv_isa_pkg.sv
hdl/rvv_ctrl_pkg.sv
hdl/vinstr_classifier.sv
hdl/vop_decoder.sv
hdl/vexec_ctrl_gen.sv
hdl/vissue_ctrl_gen.sv
hdl/vector_control_unit.sv
sim/tb_vector_control_unit.sv

/* Makefile */
# Verilator build and run of the vector control unit testbench

TOP := tb_vector_control_unit
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --top-module $(TOP) -f files.f --Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
